/* rtl/dma_pkg.sv */
// controller state and register address enums, descriptor field constants
package dma_pkg;

   typedef enum logic [2:0] {
      S_IDLE  = 3'd0,
      S_FETCH = 3'd1,    // descriptor read block
      S_EVAL  = 3'd2,    // kick the channel
      S_WAIT  = 3'd3,
      S_CTL   = 3'd4,    // completion record write block
      S_TERM  = 3'd5,
      S_NEXT  = 3'd6
   } ctrl_state_e;

   typedef enum logic [2:0] {
      REG_NDAR = 3'd0,   // next descriptor address, write
      REG_CTRL = 3'd1,   // enable, resume, irq clear
      REG_DAR  = 3'd2,   // current descriptor address, read
      REG_CSR  = 3'd3    // status, read
   } reg_addr_e;

   // beats per descriptor fetch and per writeback
   localparam int DESC_BEATS = 4;

   // control word layout
   localparam int DC_W         = 24;
   localparam int DC_CTL_BIT   = 7;
   localparam int DC_CHAIN_BIT = 14;
   localparam int DC_IRQ_BIT   = 15;

   // low lane of every writeback beat
   localparam logic [31:0] CTL_DONE_MARK = 32'hD0E5_0000;

endpackage

/* rtl/dma_regs.sv */
// host register block with the valid/ready port, sticky flags and read mux
`timescale 1ns/1ps

module dma_regs (
   input  logic               wb_clk_i,
   input  logic               wb_rst_i,
   input  logic               reg_valid_i,
   output logic               reg_ready_o,
   input  logic               reg_we_i,
   input  dma_pkg::reg_addr_e reg_addr_i,
   input  logic [31:0]        reg_wdata_i,
   output logic [31:0]        reg_rdata_o,
   output logic [31:3]        ndar_o,
   output logic               ndar_dirty_o,
   input  logic               ndar_dirty_clear_i,
   output logic               enable_o,
   output logic               resume_o,
   input  logic               resume_clear_i,
   input  logic [31:3]        dar_i,
   input  logic               busy_i,
   input  logic               int_set_i,
   input  logic               err_i,
   output logic               irq_o
);
   import dma_pkg::*;

   logic acc_q, enable_q, dirty_q, resume_q, irq_q, err_q;
   logic accept, ndar_wr, ctrl_wr, int_clr;

   assign reg_ready_o = !acc_q;           // one bubble after each access
   assign accept      = reg_valid_i && reg_ready_o;
   assign ndar_wr     = accept && reg_we_i && (reg_addr_i == REG_NDAR);
   assign ctrl_wr     = accept && reg_we_i && (reg_addr_i == REG_CTRL);
   assign int_clr     = ctrl_wr && reg_wdata_i[2];

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         acc_q    <= 1'b0;
         enable_q <= 1'b0;
         dirty_q  <= 1'b0;
         resume_q <= 1'b0;
         irq_q    <= 1'b0;
         err_q    <= 1'b0;
      end else begin
         acc_q <= accept;
         if (ctrl_wr) enable_q <= reg_wdata_i[0];
         if (ndar_wr) dirty_q <= 1'b1;                  // new write beats a late clear
         else if (ndar_dirty_clear_i) dirty_q <= 1'b0;
         if (ctrl_wr && reg_wdata_i[1]) resume_q <= 1'b1;
         else if (resume_clear_i) resume_q <= 1'b0;
         if (int_set_i != int_clr) irq_q <= int_set_i;   // set and clear together hold
         if (err_i != int_clr) err_q <= err_i;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (ndar_wr) ndar_o <= reg_wdata_i[31:3];
      if (accept && !reg_we_i) begin
         case (reg_addr_i)
            REG_DAR: reg_rdata_o <= {dar_i, 3'b000};
            REG_CSR: reg_rdata_o <= {28'd0, err_q, irq_q, busy_i, enable_q};
            default: reg_rdata_o <= 32'd0;
         endcase
      end
   end

   assign ndar_dirty_o = dirty_q;
   assign enable_o     = enable_q;
   assign resume_o     = resume_q;
   assign irq_o        = irq_q;

endmodule

/* rtl/dma_desc_ctrl.sv */
// descriptor fetch, channel wait, completion writeback and chain FSM with Wishbone master
`timescale 1ns/1ps

module dma_desc_ctrl #(
   parameter int CNT_W = 13
) (
   input  logic                 wb_clk_i,
   input  logic                 wb_rst_i,
   input  logic                 enable_i,
   input  logic [31:3]          ndar_i,
   input  logic                 ndar_dirty_i,
   input  logic                 resume_i,
   output logic                 ndar_dirty_clear_o,
   output logic                 resume_clear_o,
   output logic [31:3]          dar_o,
   output logic                 busy_o,
   output logic                 int_set_o,
   output logic                 err_o,
   output logic                 wb_cyc_o,
   output logic                 wb_stb_o,
   output logic                 wb_we_o,
   output logic [3:0]           wb_sel_o,
   output logic [31:0]          wb_adr_o,
   output logic [31:0]          wb_dat_o,
   output logic [31:0]          wb_dat64_o,
   input  logic [31:0]          wb_dat_i,
   input  logic [31:0]          wb_dat64_i,
   input  logic                 wb_ack_i,
   input  logic                 wb_rty_i,
   input  logic                 wb_err_i,
   output logic                 ch_start_o,
   output logic [CNT_W-1:0]     ch_count_o,
   output logic [31:0]          ch_base_o,
   input  logic                 ch_done_i,
   output dma_pkg::ctrl_state_e state_o
);
   import dma_pkg::*;

   localparam int BEAT_W = $clog2(DESC_BEATS);

   ctrl_state_e       state_q;
   logic              resume_mode_q;
   logic [31:3]       adr_q, cdar_q, next_q, ctl_adr_q, dar_q;
   logic [BEAT_W-1:0] beat_q;
   logic [DC_W-1:0]   dc_q;
   logic [31:0]       base_q;
   logic              fetch_go, beat_ack, last_beat;

   assign fetch_go  = (state_q == S_IDLE) && enable_i && (ndar_dirty_i || resume_i);
   assign beat_ack  = wb_stb_o && wb_ack_i && !wb_rty_i && !wb_err_i;   // rty holds the beat
   assign last_beat = beat_ack && (beat_q == BEAT_W'(DESC_BEATS - 1));

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state_q            <= S_IDLE;
         wb_cyc_o           <= 1'b0;
         wb_stb_o           <= 1'b0;
         wb_we_o            <= 1'b0;
         resume_mode_q      <= 1'b0;
         dar_q              <= '0;
         ndar_dirty_clear_o <= 1'b0;
         resume_clear_o     <= 1'b0;
         int_set_o          <= 1'b0;
         err_o              <= 1'b0;
      end else begin
         ndar_dirty_clear_o <= 1'b0;
         resume_clear_o     <= 1'b0;
         int_set_o          <= 1'b0;
         err_o              <= 1'b0;
         case (state_q)
            S_IDLE: if (fetch_go) begin
               {wb_cyc_o, wb_stb_o, wb_we_o} <= 3'b110;
               ndar_dirty_clear_o <= ndar_dirty_i;
               resume_mode_q      <= !ndar_dirty_i;   // dirty address has priority
               state_q            <= S_FETCH;
            end
            S_FETCH, S_CTL: begin
               if (wb_err_i) begin                  // bus error aborts the job
                  {wb_cyc_o, wb_stb_o, wb_we_o} <= 3'b000;
                  err_o          <= 1'b1;
                  resume_clear_o <= resume_mode_q;
                  resume_mode_q  <= 1'b0;
                  state_q        <= S_IDLE;
               end else if (last_beat) begin
                  {wb_cyc_o, wb_stb_o, wb_we_o} <= 3'b000;
                  state_q <= (state_q == S_FETCH) ? S_EVAL : S_TERM;
               end
            end
            S_EVAL: begin
               resume_clear_o <= resume_mode_q;     // resume refetches only once
               resume_mode_q  <= 1'b0;
               state_q        <= S_WAIT;
            end
            S_WAIT: if (ch_done_i) begin
               if (dc_q[DC_CTL_BIT]) begin
                  {wb_cyc_o, wb_stb_o, wb_we_o} <= 3'b111;
                  state_q <= S_CTL;
               end else begin
                  state_q <= S_TERM;
               end
            end
            S_TERM: begin
               dar_q     <= cdar_q;
               int_set_o <= dc_q[DC_IRQ_BIT];
               state_q   <= dc_q[DC_CHAIN_BIT] ? S_NEXT : S_IDLE;
            end
            S_NEXT: begin
               {wb_cyc_o, wb_stb_o, wb_we_o} <= 3'b110;
               state_q <= S_FETCH;
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   // address, beat counter and descriptor fields
   always_ff @(posedge wb_clk_i) begin
      case (state_q)
         S_IDLE:  adr_q <= ndar_dirty_i ? ndar_i : dar_q;
         S_WAIT:  adr_q <= ctl_adr_q;
         S_NEXT:  adr_q <= next_q;
         default: if (beat_ack) adr_q <= adr_q + 29'd1;   // 8 bytes per beat
      endcase
      if (state_q == S_IDLE || state_q == S_WAIT || state_q == S_NEXT) beat_q <= '0;
      else if (beat_ack) beat_q <= beat_q + 1'b1;
      if (state_q == S_FETCH && beat_ack) begin
         case (beat_q)
            BEAT_W'(0): begin
               ctl_adr_q <= wb_dat_i[31:3];
               next_q    <= wb_dat64_i[31:3];
               cdar_q    <= adr_q;
            end
            BEAT_W'(1): dc_q   <= wb_dat64_i[DC_W-1:0];
            BEAT_W'(2): base_q <= wb_dat_i;
            default: ;                                 // beat 3 unused
         endcase
      end
   end

   assign wb_sel_o   = 4'b1111;
   assign wb_adr_o   = {adr_q, 3'b000};
   assign wb_dat_o   = CTL_DONE_MARK | {{(32 - DC_W){1'b0}}, dc_q};
   assign wb_dat64_o = {cdar_q, 3'b000};

   assign ch_start_o = (state_q == S_EVAL);
   assign ch_count_o = CNT_W'({dc_q[13:8], dc_q[6:0]});
   assign ch_base_o  = base_q;

   assign dar_o   = dar_q;
   assign busy_o  = (state_q != S_IDLE);
   assign state_o = state_q;

endmodule

/* rtl/dma_fill_channel.sv */
// counted stream generator that emits base plus index and pulses done
`timescale 1ns/1ps

module dma_fill_channel #(
   parameter int CNT_W = 13
) (
   input  logic             wb_clk_i,
   input  logic             wb_rst_i,
   input  logic             start_i,
   input  logic [CNT_W-1:0] count_i,
   input  logic [31:0]      base_i,
   output logic             st_valid_o,
   input  logic             st_ready_i,
   output logic [31:0]      st_data_o,
   output logic             done_o
);

   logic [CNT_W-1:0] cnt_q, idx_q;
   logic [31:0]      base_q;
   logic             accept, last;

   assign accept = st_valid_o && st_ready_i;
   assign last   = (idx_q == cnt_q - 1'b1);

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         st_valid_o <= 1'b0;
         done_o     <= 1'b0;
         cnt_q      <= '0;
         idx_q      <= '0;
      end else begin
         done_o <= 1'b0;
         if (start_i) begin
            cnt_q <= count_i;
            idx_q <= '0;
            if (count_i == '0) begin
               done_o <= 1'b1;           // empty transfer finishes at once
            end else begin
               st_valid_o <= 1'b1;
            end
         end else if (accept) begin
            if (last) begin
               st_valid_o <= 1'b0;
               done_o     <= 1'b1;
            end else begin
               idx_q <= idx_q + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (start_i) base_q <= base_i;
   end

   // held while ready is low since idx only moves on accept
   assign st_data_o = base_q + 32'(idx_q);

endmodule

/* rtl/dma_top.sv */
// DMA top level joining host registers, descriptor controller and fill channel
`timescale 1ns/1ps

module dma_top #(
   parameter int CNT_W = 13
) (
   input  logic                 wb_clk_i,
   input  logic                 wb_rst_i,
   input  logic                 reg_valid_i,
   output logic                 reg_ready_o,
   input  logic                 reg_we_i,
   input  dma_pkg::reg_addr_e   reg_addr_i,
   input  logic [31:0]          reg_wdata_i,
   output logic [31:0]          reg_rdata_o,
   output logic                 wb_cyc_o,
   output logic                 wb_stb_o,
   output logic                 wb_we_o,
   output logic [3:0]           wb_sel_o,
   output logic [31:0]          wb_adr_o,
   output logic [31:0]          wb_dat_o,
   output logic [31:0]          wb_dat64_o,
   input  logic [31:0]          wb_dat_i,
   input  logic [31:0]          wb_dat64_i,
   input  logic                 wb_ack_i,
   input  logic                 wb_rty_i,
   input  logic                 wb_err_i,
   output logic                 st_valid_o,
   input  logic                 st_ready_i,
   output logic [31:0]          st_data_o,
   output logic                 irq_o,
   output dma_pkg::ctrl_state_e state_o
);

   logic [31:3]      ndar, dar;
   logic             ndar_dirty, ndar_dirty_clear, enable, resume, resume_clear;
   logic             busy, int_set, err;
   logic             ch_start, ch_done;
   logic [CNT_W-1:0] ch_count;
   logic [31:0]      ch_base;

   dma_regs regs0 (
      .wb_clk_i, .wb_rst_i, .reg_valid_i, .reg_ready_o, .reg_we_i, .reg_addr_i,
      .reg_wdata_i, .reg_rdata_o, .ndar_o(ndar), .ndar_dirty_o(ndar_dirty),
      .ndar_dirty_clear_i(ndar_dirty_clear), .enable_o(enable), .resume_o(resume),
      .resume_clear_i(resume_clear), .dar_i(dar), .busy_i(busy), .int_set_i(int_set),
      .err_i(err), .irq_o
   );

   dma_desc_ctrl #(.CNT_W(CNT_W)) ctrl0 (
      .wb_clk_i, .wb_rst_i, .enable_i(enable), .ndar_i(ndar), .ndar_dirty_i(ndar_dirty),
      .resume_i(resume), .ndar_dirty_clear_o(ndar_dirty_clear), .resume_clear_o(resume_clear),
      .dar_o(dar), .busy_o(busy), .int_set_o(int_set), .err_o(err),
      .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_sel_o, .wb_adr_o, .wb_dat_o, .wb_dat64_o,
      .wb_dat_i, .wb_dat64_i, .wb_ack_i, .wb_rty_i, .wb_err_i,
      .ch_start_o(ch_start), .ch_count_o(ch_count), .ch_base_o(ch_base),
      .ch_done_i(ch_done), .state_o
   );

   dma_fill_channel #(.CNT_W(CNT_W)) chan0 (
      .wb_clk_i, .wb_rst_i, .start_i(ch_start), .count_i(ch_count), .base_i(ch_base),
      .st_valid_o, .st_ready_i, .st_data_o, .done_o(ch_done)
   );

endmodule

/* tb/dma_mem_model.sv */
// Wishbone slave memory with two 32-bit lanes, random wait states, retry and error injection
`timescale 1ns/1ps

module dma_mem_model (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        wb_cyc_i,
   input  logic        wb_stb_i,
   input  logic        wb_we_i,
   input  logic [31:0] wb_adr_i,
   input  logic [31:0] wb_dat_i,
   input  logic [31:0] wb_dat64_i,
   output logic [31:0] wb_dat_o,
   output logic [31:0] wb_dat64_o,
   output logic        wb_ack_o,
   output logic        wb_rty_o,
   output logic        wb_err_o,
   input  logic        err_en_i,
   input  logic [31:0] err_adr_i
);

   logic [63:0] mem [0:255];   // one 64-bit word per 8-byte step
   integer      seed = 32'h8890;
   int          roll;
   logic [7:0]  idx;

   assign idx = wb_adr_i[10:3];

   initial begin
      int i;
      for (i = 0; i < 256; i++) begin
         mem[i] = {32'hA500_0000 | 32'(i), ~32'(i)};   // pattern follows the index
      end
   end

   always @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wb_ack_o <= 1'b0;
         wb_rty_o <= 1'b0;
         wb_err_o <= 1'b0;
      end else begin
         wb_ack_o <= 1'b0;
         wb_rty_o <= 1'b0;
         wb_err_o <= 1'b0;
         // one response per beat, the master moves on after it
         if (wb_cyc_i && wb_stb_i && !(wb_ack_o || wb_rty_o || wb_err_o)) begin
            roll = $random(seed) & 7;
            if (err_en_i && (wb_adr_i == err_adr_i)) begin
               wb_err_o <= 1'b1;
            end else if (roll == 0) begin
               wb_rty_o <= 1'b1;                   // beat must be repeated
            end else if (roll > 2) begin            // rolls 1 and 2 are wait states
               wb_ack_o <= 1'b1;
               if (wb_we_i) mem[idx] <= {wb_dat64_i, wb_dat_i};
               wb_dat_o   <= mem[idx][31:0];
               wb_dat64_o <= mem[idx][63:32];
            end
         end
      end
   end

endmodule

/* tb/dma_properties.sv */
// concurrent assertions on the Wishbone master, the output stream and the channel start
`timescale 1ns/1ps

module dma_properties (
   input logic                 wb_clk_i,
   input logic                 wb_rst_i,
   input logic                 wb_cyc_i,
   input logic                 wb_stb_i,
   input logic                 wb_ack_i,
   input logic                 wb_err_i,
   input logic [31:0]          wb_adr_i,
   input logic                 st_valid_i,
   input logic                 st_ready_i,
   input logic [31:0]          st_data_i,
   input logic                 ch_start_i,
   input dma_pkg::ctrl_state_e state_i
);
   import dma_pkg::*;

   stb_held: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      wb_stb_i && !wb_ack_i && !wb_err_i |=> wb_stb_i && wb_cyc_i)
      else $error("wb_stb_o or wb_cyc_o dropped before the beat was answered");

   adr_held: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      wb_stb_i && !wb_ack_i |=> !wb_stb_i || $stable(wb_adr_i))
      else $error("wb_adr_o moved before the beat was acknowledged");

   stream_held: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      st_valid_i && !st_ready_i |=> st_valid_i && $stable(st_data_i))
      else $error("stream word changed under back-pressure");

   start_in_eval: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      ch_start_i |-> state_i == S_EVAL && $past(state_i) == S_FETCH && $past(wb_ack_i))
      else $error("channel start without a just completed descriptor fetch");

endmodule

// checker on the top level, where the bus and the stream meet
bind dma_top dma_properties props0 (
   .wb_clk_i, .wb_rst_i, .wb_cyc_i(wb_cyc_o), .wb_stb_i(wb_stb_o), .wb_ack_i, .wb_err_i,
   .wb_adr_i(wb_adr_o), .st_valid_i(st_valid_o), .st_ready_i, .st_data_i(st_data_o),
   .ch_start_i(ch_start), .state_i(state_o)
);

/* tb/tb_dma.sv */
// testbench with random descriptor chains, a reference model and stream, register and memory checks
`timescale 1ns/1ps

module tb_dma;
   import dma_pkg::*;

   logic        wb_clk_i, wb_rst_i, reg_valid, reg_ready, reg_we, cyc, stb, we, ack, rty, err;
   reg_addr_e   reg_addr;
   logic [31:0] reg_wdata, reg_rdata, adr, m_dat, m_dat64, s_dat, s_dat64, st_data, err_adr;
   logic [3:0]  sel;
   logic        st_valid, st_ready, irq, err_en, exp_irq;
   ctrl_state_e state;
   integer      seed = 32'h8890;
   int          errors, checks, tests, err_mark;
   logic [31:0] exp_q [$];        // predicted stream words
   logic [63:0] shadow [0:255];   // predicted memory contents
   logic [31:0] exp_dar;

   dma_top #(.CNT_W(13)) dut0 (
      .wb_clk_i, .wb_rst_i, .reg_valid_i(reg_valid), .reg_ready_o(reg_ready),
      .reg_we_i(reg_we), .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata),
      .wb_cyc_o(cyc), .wb_stb_o(stb), .wb_we_o(we), .wb_sel_o(sel), .wb_adr_o(adr),
      .wb_dat_o(m_dat), .wb_dat64_o(m_dat64), .wb_dat_i(s_dat), .wb_dat64_i(s_dat64),
      .wb_ack_i(ack), .wb_rty_i(rty), .wb_err_i(err), .st_valid_o(st_valid),
      .st_ready_i(st_ready), .st_data_o(st_data), .irq_o(irq), .state_o(state)
   );

   dma_mem_model mem0 (
      .wb_clk_i, .wb_rst_i, .wb_cyc_i(cyc), .wb_stb_i(stb), .wb_we_i(we), .wb_adr_i(adr),
      .wb_dat_i(m_dat), .wb_dat64_i(m_dat64), .wb_dat_o(s_dat), .wb_dat64_o(s_dat64),
      .wb_ack_o(ack), .wb_rty_o(rty), .wb_err_o(err), .err_en_i(err_en), .err_adr_i(err_adr)
   );

   initial begin
      wb_clk_i = 1'b0;
      forever #10 wb_clk_i = ~wb_clk_i;
   end

   always @(posedge wb_clk_i) begin
      #2 st_ready <= ($random(seed) & 3) != 0;   // ready three cycles in four
   end

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // sampled at the falling edge, the handshake completes at the next rising one
   always @(negedge wb_clk_i) begin
      if (stb) check("wb_sel_o", sel, 4'hf);   // full lanes on every beat
      if (st_valid && st_ready) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("stream word %h arrived when none was expected", st_data);
         end else begin
            check("st_data_o", st_data, exp_q.pop_front());
         end
      end
   end

   task automatic abort_run(input string what);
      $display("timeout while waiting for %s", what);
      $display("TB FAILED");
      $finish;
   endtask

   task automatic reg_access(input logic wr, input reg_addr_e a, input logic [31:0] d,
                             output logic [31:0] rd);
      int n;
      n = 0;
      @(posedge wb_clk_i);
      #2;
      reg_valid = 1'b1;
      reg_we    = wr;
      reg_addr  = a;
      reg_wdata = d;
      @(negedge wb_clk_i);
      while (!reg_ready) begin
         n++;
         if (n > 20) abort_run("register port ready");
         @(negedge wb_clk_i);
      end
      @(posedge wb_clk_i);
      #2 reg_valid = 1'b0;
      @(negedge wb_clk_i);
      rd = reg_rdata;              // read data is registered at acceptance
   endtask

   task automatic wait_job();
      int n;
      n = 0;
      while (state == S_IDLE) begin
         n++;
         if (n > 50) abort_run("the controller to leave idle");
         @(negedge wb_clk_i);
      end
      n = 0;
      while (state != S_IDLE) begin
         n++;
         if (n > 20000) abort_run("the controller to return to idle");
         @(negedge wb_clk_i);
      end
      repeat (3) @(negedge wb_clk_i);   // irq lands two cycles after S_TERM
   endtask

   // descriptor at slot*16 words, its completion record 8 words further
   task automatic put_desc(input int slot, input logic ctl, input logic irqb,
                           input logic chain, input int next_slot);
      logic [12:0] cnt;
      logic [23:0] dc;
      int d, k;
      d   = slot * 16;
      cnt = 13'($unsigned($random(seed)) % 160);
      dc  = {8'($random(seed)), irqb, chain, cnt[12:7], ctl, cnt[6:0]};
      shadow[d]     = {32'(next_slot * 128), 32'((d + 8) * 8)};
      shadow[d + 1] = {8'($random(seed)), dc, 32'($random(seed))};
      shadow[d + 2] = {32'($random(seed)), 32'($random(seed))};
      shadow[d + 3] = {32'($random(seed)), 32'($random(seed))};
      for (k = 0; k < 4; k++) begin
         mem0.mem[d + k] = shadow[d + k];
      end
   endtask

   task automatic predict(input int slot);
      logic [23:0] dc;
      logic [12:0] cnt;
      int d, c, k;
      d   = slot * 16;
      dc  = shadow[d + 1][55:32];
      cnt = {dc[13:8], dc[6:0]};
      c   = shadow[d][31:0] / 8;
      for (k = 0; k < cnt; k++) begin
         exp_q.push_back(shadow[d + 2][31:0] + 32'(k));
      end
      if (dc[DC_CTL_BIT]) begin
         for (k = 0; k < DESC_BEATS; k++) begin
            shadow[c + k] = {32'(d * 8), CTL_DONE_MARK | {8'd0, dc}};
         end
      end
      if (dc[DC_IRQ_BIT]) exp_irq = 1'b1;
      exp_dar = 32'(d * 8);
   endtask

   task automatic check_state(input logic exp_err);
      logic [31:0] rd;
      int k;
      check("stream words left", exp_q.size(), 0);
      reg_access(1'b0, REG_DAR, 32'd0, rd);
      check("reg_rdata_o DAR", rd, exp_dar);
      reg_access(1'b0, REG_CSR, 32'd0, rd);
      check("reg_rdata_o CSR", rd, {28'd0, exp_err, exp_irq, 1'b0, 1'b1});
      check("irq_o", irq, exp_irq);
      for (k = 0; k < 256; k++) begin
         check($sformatf("mem[%0d]", k), mem0.mem[k], shadow[k]);
      end
   endtask

   task automatic finish_test(input string name);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == err_mark) ? "ok" : "mismatches");
      err_mark = errors;
   endtask

   initial begin
      logic [31:0] rd;
      int k;
      {reg_valid, reg_we, reg_wdata, st_ready, err_en, err_adr} = '0;
      reg_addr = REG_NDAR;
      {errors, checks, tests, err_mark} = '0;
      exp_irq  = 1'b0;
      exp_dar  = 32'd0;
      wb_rst_i = 1'b1;
      repeat (16) @(posedge wb_clk_i);
      #2 wb_rst_i = 1'b0;
      for (k = 0; k < 256; k++) begin
         shadow[k] = mem0.mem[k];
      end

      put_desc(7, 1'b0, 1'b0, 1'b0, 0);
      predict(7);
      reg_access(1'b1, REG_NDAR, 32'd896, rd);
      reg_access(1'b1, REG_CTRL, 32'd1, rd);      // enable
      wait_job();
      check_state(1'b0);
      finish_test("single descriptor");

      put_desc(3, 1'($random(seed)), 1'($random(seed)), 1'b0, 0);
      put_desc(2, 1'($random(seed)), 1'($random(seed)), 1'b1, 3);
      put_desc(1, 1'($random(seed)), 1'($random(seed)), 1'b1, 2);
      for (k = 1; k < 4; k++) begin
         predict(k);
      end
      reg_access(1'b1, REG_NDAR, 32'd128, rd);
      wait_job();
      check_state(1'b0);
      finish_test("chain of three");

      put_desc(5, 1'b1, 1'($random(seed)), 1'b0, 0);
      put_desc(4, 1'b1, 1'b1, 1'b1, 5);
      predict(4);
      predict(5);
      reg_access(1'b1, REG_NDAR, 32'd512, rd);
      wait_job();
      check_state(1'b0);
      finish_test("completion writeback");

      reg_access(1'b1, REG_CTRL, 32'd5, rd);      // enable and irq clear
      exp_irq = 1'b0;
      reg_access(1'b0, REG_CSR, 32'd0, rd);
      check("reg_rdata_o CSR irq", rd[2], 1'b0);
      predict(5);
      reg_access(1'b1, REG_CTRL, 32'd3, rd);      // enable and resume
      wait_job();
      check_state(1'b0);
      finish_test("irq clear and resume");

      put_desc(6, 1'b0, 1'b0, 1'b0, 0);
      err_adr = 32'd768;
      err_en  = 1'b1;
      reg_access(1'b1, REG_NDAR, 32'd768, rd);
      wait_job();
      err_en = 1'b0;
      check_state(1'b1);
      finish_test("fetch error abort");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* build.f */
rtl/dma_pkg.sv
rtl/dma_regs.sv
rtl/dma_desc_ctrl.sv
rtl/dma_fill_channel.sv
rtl/dma_top.sv
tb/dma_mem_model.sv
tb/dma_properties.sv
tb/tb_dma.sv
